// ==== wcache_macros.svh ====
/*
 * Widths, write buffer depth and source ids
 * for the data cache memory write path
 */
`ifndef WC_MACROS_SVH
`define WC_MACROS_SVH

`define WC_ADDR_W       32
`define WC_DATA_W       32
`define WC_BE_W         (`WC_DATA_W / 8)
`define WC_ID_W         1

`define WC_NSRC         2
`define WC_WBUF_DEPTH   4
`define WC_WBUF_PTR_W   2
`define WC_WBUF_CNT_W   3

// Source ids, also the arbiter indices (lower wins)
`define WC_ID_UC        1'b0
`define WC_ID_WBUF      1'b1

`endif

// ==== wcache_mem_pkg.sv ====
/*
 * Memory-side vector types
 * Address, data word, byte enables and source id
 */
`default_nettype none

`include "wcache_macros.svh"

package wcache_mem_pkg;

    // Byte address
    typedef logic [`WC_ADDR_W-1:0] mem_addr_t;

    typedef logic [`WC_DATA_W-1:0] mem_data_t;
    typedef logic [`WC_BE_W-1:0]   mem_be_t;

    // Source id carried with each request
    typedef logic [`WC_ID_W-1:0]   mem_id_t;

endpackage

`default_nettype wire

// ==== wcache_ctrl_pkg.sv ====
/*
 * State machine encodings for the arbiter and the write sources
 */
`default_nettype none

package wcache_ctrl_pkg;

    // Which half of the granted write has already left the arbiter
    typedef enum logic [1:0] {
        SEND_IDLE,
        SEND_REQ_DONE,
        SEND_DATA_DONE
    } req_send_state_t;

    // Progress of a source's head write
    typedef enum logic [1:0] {
        SRC_IDLE,
        SRC_REQ_DONE,
        SRC_DATA_DONE
    } src_state_t;

endpackage

`default_nettype wire

// ==== mem_wr_if.sv ====
/*
 * One source's memory write channels
 * Request channel (address, id) and data channel (data, byte enables)
 */
`default_nettype none

interface mem_wr_if;

    // Request channel
    logic                      req_valid;
    logic                      req_ready;
    wcache_mem_pkg::mem_addr_t req_addr;
    wcache_mem_pkg::mem_id_t   req_id;

    // Data channel
    logic                      data_valid;
    logic                      data_ready;
    wcache_mem_pkg::mem_data_t data;
    wcache_mem_pkg::mem_be_t   be;

    modport src (
        output req_valid, req_addr, req_id,
        output data_valid, data, be,
        input  req_ready, data_ready
    );

    modport arb (
        input  req_valid, req_addr, req_id,
        input  data_valid, data, be,
        output req_ready, data_ready
    );

endinterface

`default_nettype wire

// ==== wcache_fxarb.sv ====
/*
 * Fixed-priority arbiter with held grant
 * Lowest index wins, grant kept until released
 */
`default_nettype none

`include "wcache_macros.svh"

module wcache_fxarb (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic [`WC_NSRC-1:0] req_i,
    output logic [`WC_NSRC-1:0] gnt_o,
    input  logic                release_i
);

    logic [`WC_NSRC-1:0] pri_gnt;
    logic [`WC_NSRC-1:0] gnt_q;
    logic                held_q;

    // Scan from the top so the lowest requester is the last one kept
    always_comb begin
        pri_gnt = '0;
        for (int i = `WC_NSRC - 1; i >= 0; i--) begin
            if (req_i[i]) begin
                pri_gnt    = '0;
                pri_gnt[i] = 1'b1;
            end
        end
    end

    // Fresh grant goes out in the same cycle, then stays latched
    assign gnt_o = held_q ? gnt_q : pri_gnt;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            held_q <= 1'b0;
            gnt_q  <= '0;
        end else if (release_i) begin
            held_q <= 1'b0;
        end else if (!held_q && (|req_i)) begin
            held_q <= 1'b1;
            gnt_q  <= pri_gnt;
        end
    end

endmodule

`default_nettype wire

// ==== mem_write_arbiter.sv ====
/*
 * Memory write channel arbiter
 * Keeps each granted request paired with its own data beat
 */
`default_nettype none

`include "wcache_macros.svh"

module mem_write_arbiter (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    mem_wr_if.arb                     src_uc,
    mem_wr_if.arb                     src_wbuf,

    output logic                      mem_req_valid_o,
    input  logic                      mem_req_ready_i,
    output wcache_mem_pkg::mem_addr_t mem_req_addr_o,
    output wcache_mem_pkg::mem_id_t   mem_req_id_o,

    output logic                      mem_data_valid_o,
    input  logic                      mem_data_ready_i,
    output wcache_mem_pkg::mem_data_t mem_data_o,
    output wcache_mem_pkg::mem_be_t   mem_be_o
);

    wcache_ctrl_pkg::req_send_state_t send_q, send_d;

    logic [`WC_NSRC-1:0]       src_req_valid;
    logic [`WC_NSRC-1:0]       src_data_valid;
    logic [`WC_NSRC-1:0]       gnt;
    wcache_mem_pkg::mem_addr_t src_addr [`WC_NSRC];
    wcache_mem_pkg::mem_id_t   src_id   [`WC_NSRC];
    wcache_mem_pkg::mem_data_t src_data [`WC_NSRC];
    wcache_mem_pkg::mem_be_t   src_be   [`WC_NSRC];

    logic req_valid;
    logic data_valid;
    logic req_fire;
    logic data_fire;
    logic req_ready_ok;
    logic data_ready_ok;
    logic pair_done;

    // Gather both sources by their id
    assign src_req_valid[`WC_ID_UC]    = src_uc.req_valid;
    assign src_req_valid[`WC_ID_WBUF]  = src_wbuf.req_valid;
    assign src_data_valid[`WC_ID_UC]   = src_uc.data_valid;
    assign src_data_valid[`WC_ID_WBUF] = src_wbuf.data_valid;
    assign src_addr[`WC_ID_UC]         = src_uc.req_addr;
    assign src_addr[`WC_ID_WBUF]       = src_wbuf.req_addr;
    assign src_id[`WC_ID_UC]           = src_uc.req_id;
    assign src_id[`WC_ID_WBUF]         = src_wbuf.req_id;
    assign src_data[`WC_ID_UC]         = src_uc.data;
    assign src_data[`WC_ID_WBUF]       = src_wbuf.data;
    assign src_be[`WC_ID_UC]           = src_uc.be;
    assign src_be[`WC_ID_WBUF]         = src_wbuf.be;

    wcache_fxarb u_fxarb (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .req_i     (src_req_valid | src_data_valid),
        .gnt_o     (gnt),
        .release_i (pair_done)
    );

    // A half that already went out stays masked until its partner goes
    assign req_ready_ok  = (send_q != wcache_ctrl_pkg::SEND_REQ_DONE);
    assign data_ready_ok = (send_q != wcache_ctrl_pkg::SEND_DATA_DONE);

    assign req_valid  = |(gnt & src_req_valid);
    assign data_valid = |(gnt & src_data_valid);

    assign mem_req_valid_o  = req_valid & req_ready_ok;
    assign mem_data_valid_o = data_valid & data_ready_ok;

    assign req_fire  = mem_req_valid_o & mem_req_ready_i;
    assign data_fire = mem_data_valid_o & mem_data_ready_i;

    always_comb begin
        send_d    = send_q;
        pair_done = 1'b0;
        case (send_q)
            wcache_ctrl_pkg::SEND_IDLE: begin
                if (req_fire && data_fire) begin
                    pair_done = 1'b1;
                end else if (req_fire) begin
                    send_d = wcache_ctrl_pkg::SEND_REQ_DONE;
                end else if (data_fire) begin
                    send_d = wcache_ctrl_pkg::SEND_DATA_DONE;
                end
            end
            wcache_ctrl_pkg::SEND_REQ_DONE: begin
                if (data_fire) begin
                    pair_done = 1'b1;
                    send_d    = wcache_ctrl_pkg::SEND_IDLE;
                end
            end
            wcache_ctrl_pkg::SEND_DATA_DONE: begin
                if (req_fire) begin
                    pair_done = 1'b1;
                    send_d    = wcache_ctrl_pkg::SEND_IDLE;
                end
            end
            default: send_d = wcache_ctrl_pkg::SEND_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            send_q <= wcache_ctrl_pkg::SEND_IDLE;
        end else begin
            send_q <= send_d;
        end
    end

    assign src_uc.req_ready    = gnt[`WC_ID_UC] & mem_req_ready_i & req_ready_ok;
    assign src_wbuf.req_ready  = gnt[`WC_ID_WBUF] & mem_req_ready_i & req_ready_ok;
    assign src_uc.data_ready   = gnt[`WC_ID_UC] & mem_data_ready_i & data_ready_ok;
    assign src_wbuf.data_ready = gnt[`WC_ID_WBUF] & mem_data_ready_i & data_ready_ok;

    // One-hot payload mux
    always_comb begin
        mem_req_addr_o = '0;
        mem_req_id_o   = '0;
        mem_data_o     = '0;
        mem_be_o       = '0;
        for (int i = 0; i < `WC_NSRC; i++) begin
            if (gnt[i]) begin
                mem_req_addr_o = mem_req_addr_o | src_addr[i];
                mem_req_id_o   = mem_req_id_o | src_id[i];
                mem_data_o     = mem_data_o | src_data[i];
                mem_be_o       = mem_be_o | src_be[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== wbuf_drain.sv ====
/*
 * Four-entry store buffer draining onto the memory write channels
 */
`default_nettype none

`include "wcache_macros.svh"

module wbuf_drain (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      st_valid_i,
    output logic                      st_ready_o,
    input  wcache_mem_pkg::mem_addr_t st_addr_i,
    input  wcache_mem_pkg::mem_data_t st_data_i,
    input  wcache_mem_pkg::mem_be_t   st_be_i,
    mem_wr_if.src                     mem
);

    wcache_mem_pkg::mem_addr_t addr_q [`WC_WBUF_DEPTH];
    wcache_mem_pkg::mem_data_t data_q [`WC_WBUF_DEPTH];
    wcache_mem_pkg::mem_be_t   be_q   [`WC_WBUF_DEPTH];

    logic [`WC_WBUF_PTR_W-1:0] wr_ptr_q;
    logic [`WC_WBUF_PTR_W-1:0] rd_ptr_q;
    logic [`WC_WBUF_CNT_W-1:0] count_q;
    wcache_ctrl_pkg::src_state_t state_q;

    logic push;
    logic pop;
    logic req_fire;
    logic data_fire;

    assign st_ready_o = (count_q != `WC_WBUF_CNT_W'(`WC_WBUF_DEPTH));
    assign push       = st_valid_i & st_ready_o;

    // Head entry, both halves offered until each has left
    assign mem.req_valid  = (count_q != '0) && (state_q != wcache_ctrl_pkg::SRC_REQ_DONE);
    assign mem.data_valid = (count_q != '0) && (state_q != wcache_ctrl_pkg::SRC_DATA_DONE);
    assign mem.req_addr   = addr_q[rd_ptr_q];
    assign mem.req_id     = `WC_ID_WBUF;
    assign mem.data       = data_q[rd_ptr_q];
    assign mem.be         = be_q[rd_ptr_q];

    assign req_fire  = mem.req_valid & mem.req_ready;
    assign data_fire = mem.data_valid & mem.data_ready;

    assign pop = ((state_q == wcache_ctrl_pkg::SRC_IDLE) && req_fire && data_fire) ||
                 ((state_q == wcache_ctrl_pkg::SRC_REQ_DONE) && data_fire) ||
                 ((state_q == wcache_ctrl_pkg::SRC_DATA_DONE) && req_fire);

    always_ff @(posedge clk_i) begin
        if (push) begin
            addr_q[wr_ptr_q] <= st_addr_i;
            data_q[wr_ptr_q] <= st_data_i;
            be_q[wr_ptr_q]   <= st_be_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            state_q  <= wcache_ctrl_pkg::SRC_IDLE;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
                state_q  <= wcache_ctrl_pkg::SRC_IDLE;
            end else if (req_fire) begin
                state_q <= wcache_ctrl_pkg::SRC_REQ_DONE;
            end else if (data_fire) begin
                state_q <= wcache_ctrl_pkg::SRC_DATA_DONE;
            end
            // Push and pop together leave the count unchanged
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== uc_write.sv ====
/*
 * Single-entry uncached write unit
 */
`default_nettype none

`include "wcache_macros.svh"

module uc_write (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      uc_valid_i,
    output logic                      uc_ready_o,
    input  wcache_mem_pkg::mem_addr_t uc_addr_i,
    input  wcache_mem_pkg::mem_data_t uc_data_i,
    input  wcache_mem_pkg::mem_be_t   uc_be_i,
    mem_wr_if.src                     mem
);

    wcache_mem_pkg::mem_addr_t   addr_q;
    wcache_mem_pkg::mem_data_t   data_q;
    wcache_mem_pkg::mem_be_t     be_q;
    logic                        full_q;
    wcache_ctrl_pkg::src_state_t state_q;

    logic accept;
    logic req_fire;
    logic data_fire;
    logic done;

    assign uc_ready_o = ~full_q;
    assign accept     = uc_valid_i & ~full_q;

    assign mem.req_valid  = full_q && (state_q != wcache_ctrl_pkg::SRC_REQ_DONE);
    assign mem.data_valid = full_q && (state_q != wcache_ctrl_pkg::SRC_DATA_DONE);
    assign mem.req_addr   = addr_q;
    assign mem.req_id     = `WC_ID_UC;
    assign mem.data       = data_q;
    assign mem.be         = be_q;

    assign req_fire  = mem.req_valid & mem.req_ready;
    assign data_fire = mem.data_valid & mem.data_ready;

    // Register frees once both halves have left
    assign done = ((state_q == wcache_ctrl_pkg::SRC_IDLE) && req_fire && data_fire) ||
                  ((state_q == wcache_ctrl_pkg::SRC_REQ_DONE) && data_fire) ||
                  ((state_q == wcache_ctrl_pkg::SRC_DATA_DONE) && req_fire);

    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q <= uc_addr_i;
            data_q <= uc_data_i;
            be_q   <= uc_be_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q  <= 1'b0;
            state_q <= wcache_ctrl_pkg::SRC_IDLE;
        end else if (accept) begin
            full_q <= 1'b1;
        end else if (done) begin
            full_q  <= 1'b0;
            state_q <= wcache_ctrl_pkg::SRC_IDLE;
        end else if (req_fire) begin
            state_q <= wcache_ctrl_pkg::SRC_REQ_DONE;
        end else if (data_fire) begin
            state_q <= wcache_ctrl_pkg::SRC_DATA_DONE;
        end
    end

endmodule

`default_nettype wire

// ==== dcache_wr_top.sv ====
/*
 * Data cache memory write path top level
 * Store buffer and uncached unit sharing one memory write port
 */
`default_nettype none

module dcache_wr_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    input  logic                      st_valid_i,
    output logic                      st_ready_o,
    input  wcache_mem_pkg::mem_addr_t st_addr_i,
    input  wcache_mem_pkg::mem_data_t st_data_i,
    input  wcache_mem_pkg::mem_be_t   st_be_i,

    input  logic                      uc_valid_i,
    output logic                      uc_ready_o,
    input  wcache_mem_pkg::mem_addr_t uc_addr_i,
    input  wcache_mem_pkg::mem_data_t uc_data_i,
    input  wcache_mem_pkg::mem_be_t   uc_be_i,

    output logic                      mem_req_valid_o,
    input  logic                      mem_req_ready_i,
    output wcache_mem_pkg::mem_addr_t mem_req_addr_o,
    output wcache_mem_pkg::mem_id_t   mem_req_id_o,
    output logic                      mem_data_valid_o,
    input  logic                      mem_data_ready_i,
    output wcache_mem_pkg::mem_data_t mem_data_o,
    output wcache_mem_pkg::mem_be_t   mem_be_o
);

    mem_wr_if wbuf_if ();
    mem_wr_if uc_if ();

    wbuf_drain u_wbuf (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .st_valid_i (st_valid_i),
        .st_ready_o (st_ready_o),
        .st_addr_i  (st_addr_i),
        .st_data_i  (st_data_i),
        .st_be_i    (st_be_i),
        .mem        (wbuf_if.src)
    );

    uc_write u_uc (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .uc_valid_i (uc_valid_i),
        .uc_ready_o (uc_ready_o),
        .uc_addr_i  (uc_addr_i),
        .uc_data_i  (uc_data_i),
        .uc_be_i    (uc_be_i),
        .mem        (uc_if.src)
    );

    mem_write_arbiter u_arb (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .src_uc           (uc_if.arb),
        .src_wbuf         (wbuf_if.arb),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_req_addr_o   (mem_req_addr_o),
        .mem_req_id_o     (mem_req_id_o),
        .mem_data_valid_o (mem_data_valid_o),
        .mem_data_ready_i (mem_data_ready_i),
        .mem_data_o       (mem_data_o),
        .mem_be_o         (mem_be_o)
    );

endmodule

`default_nettype wire

// ==== dcache_wr_chk.sv ====
/*
 * Concurrent checks on the memory write channels
 * Valid held with a stable payload, requests and data beats kept in step
 */
`default_nettype none

module dcache_wr_chk (
    input logic                      clk_i,
    input logic                      rst_ni,
    input logic                      req_valid_i,
    input logic                      req_ready_i,
    input wcache_mem_pkg::mem_addr_t req_addr_i,
    input wcache_mem_pkg::mem_id_t   req_id_i,
    input logic                      data_valid_i,
    input logic                      data_ready_i,
    input wcache_mem_pkg::mem_data_t data_i,
    input wcache_mem_pkg::mem_be_t   be_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // Requests sent minus data beats sent
    logic signed [2:0] lead_q;

    // Number of failed assertions
    int fail_count = 0;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lead_q <= '0;
        end else begin
            lead_q <= lead_q + $signed({2'b00, req_valid_i & req_ready_i})
                             - $signed({2'b00, data_valid_i & data_ready_i});
        end
    end

    req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_addr_i) && $stable(req_id_i))
        else begin
            $error("request valid dropped or payload changed before its transfer");
            fail_count++;
        end

    data_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_valid_i && !data_ready_i |=> data_valid_i && $stable(data_i) && $stable(be_i))
        else begin
            $error("data valid dropped or payload changed before its transfer");
            fail_count++;
        end

    in_step: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (lead_q >= -3'sd1) && (lead_q <= 3'sd1))
        else begin
            $error("requests and data beats drifted more than one apart");
            fail_count++;
        end

endmodule

bind mem_write_arbiter dcache_wr_chk u_chk (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (mem_req_valid_o),
    .req_ready_i  (mem_req_ready_i),
    .req_addr_i   (mem_req_addr_o),
    .req_id_i     (mem_req_id_o),
    .data_valid_i (mem_data_valid_o),
    .data_ready_i (mem_data_ready_i),
    .data_i       (mem_data_o),
    .be_i         (mem_be_o)
);

`default_nettype wire

// ==== dcache_wr_tb.sv ====
/*
 * Testbench for the data cache write path
 * Vector-driven stimulus, memory model with ready modes, scoreboard and report
 */
`default_nettype none

`include "wcache_macros.svh"

module dcache_wr_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_VEC = 32;
    localparam logic [3:0] KIND_GAP = 4'h0;
    localparam logic [3:0] KIND_ST = 4'h1;
    localparam logic [3:0] KIND_UC = 4'h2;
    localparam logic [3:0] KIND_BOTH = 4'h3;
    localparam logic [3:0] KIND_FULL = 4'h4;
    localparam logic [3:0] MODE_ALWAYS = 4'h0;
    localparam logic [3:0] MODE_RANDOM = 4'h1;

    logic clk_i;
    logic rst_ni;
    logic st_valid_i;
    logic st_ready_o;
    wcache_mem_pkg::mem_addr_t st_addr_i;
    wcache_mem_pkg::mem_data_t st_data_i;
    wcache_mem_pkg::mem_be_t st_be_i;
    logic uc_valid_i;
    logic uc_ready_o;
    wcache_mem_pkg::mem_addr_t uc_addr_i;
    wcache_mem_pkg::mem_data_t uc_data_i;
    wcache_mem_pkg::mem_be_t uc_be_i;
    logic mem_req_valid_o;
    logic mem_req_ready_i;
    wcache_mem_pkg::mem_addr_t mem_req_addr_o;
    wcache_mem_pkg::mem_id_t mem_req_id_o;
    logic mem_data_valid_o;
    logic mem_data_ready_i;
    wcache_mem_pkg::mem_data_t mem_data_o;
    wcache_mem_pkg::mem_be_t mem_be_o;

    // Vector fields: test, kind, mode, addr, data, be
    logic [79:0] vectors [MAX_VEC];
    int n_vec = 0;
    logic [3:0] ready_mode = 4'h2;

    // Expected writes {addr, data, be}, one queue per source
    logic [67:0] exp_uc [$];
    logic [67:0] exp_wb [$];
    logic [32:0] req_q [$];
    logic [35:0] data_q [$];

    int errors = 0;
    int checks = 0;
    int test_pairs = 0;
    int tests_run = 0;
    int tests_failed = 0;
    logic first_set;
    logic first_checked;
    logic first_exp;

    dcache_wr_top uut (.*);

    always #4 clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (exp === got) else begin
            errors++;
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_pair(input logic [32:0] rq, input logic [35:0] dt);
        logic [67:0] exp;
        if (rq[32] == `WC_ID_UC) begin
            assert (exp_uc.size() > 0) else begin
                errors++;
                $display("FAIL %0t: uncached write reached memory with none pending", $time);
                return;
            end
            exp = exp_uc.pop_front();
        end else begin
            assert (exp_wb.size() > 0) else begin
                errors++;
                $display("FAIL %0t: store reached memory with none pending", $time);
                return;
            end
            exp = exp_wb.pop_front();
        end
        check_value("mem_req_addr_o", exp[67:36], rq[31:0]);
        check_value("mem_data_o", exp[35:4], dt[35:4]);
        check_value("mem_be_o", 32'(exp[3:0]), 32'(dt[3:0]));
        // With the path idle, the earliest accepted source goes first, uncached on a tie
        if (!first_checked) begin
            check_value("mem_req_id_o", 32'(first_exp), 32'(rq[32]));
            first_checked = 1'b1;
        end
        test_pairs++;
    endtask

    // Hold valids until each handshake, record the write when accepted
    task automatic issue(input logic do_st, input logic do_uc,
                         input logic [67:0] st_w, input logic [67:0] uc_w);
        logic st_pend;
        logic uc_pend;
        logic st_go;
        logic uc_go;
        st_pend = do_st;
        uc_pend = do_uc;
        st_valid_i = do_st;
        uc_valid_i = do_uc;
        if (do_st) {st_addr_i, st_data_i, st_be_i} = st_w;
        if (do_uc) {uc_addr_i, uc_data_i, uc_be_i} = uc_w;
        while (st_pend || uc_pend) begin
            @(negedge clk_i);
            st_go = st_pend && st_ready_o;
            uc_go = uc_pend && uc_ready_o;
            @(posedge clk_i);
            if (st_go) begin
                exp_wb.push_back(st_w);
                st_pend = 1'b0;
            end
            if (uc_go) begin
                exp_uc.push_back(uc_w);
                uc_pend = 1'b0;
            end
            #1;
            st_valid_i = st_pend;
            uc_valid_i = uc_pend;
        end
    endtask

    task automatic finish_test(input int t, input int err_start);
        if (ready_mode != MODE_RANDOM) ready_mode = MODE_ALWAYS;
        while (exp_uc.size() + exp_wb.size() + req_q.size() + data_q.size() != 0) begin
            @(posedge clk_i);
        end
        @(posedge clk_i);
        #1;
        tests_run++;
        if (errors != err_start) tests_failed++;
        $display("test %0d: %0d writes checked, %0d errors", t, test_pairs, errors - err_start);
    endtask

    // Memory model readies, changed just after each rising edge
    initial begin
        void'($urandom(32'ha8b786e3));
        forever begin
            @(posedge clk_i);
            #1;
            if (ready_mode == MODE_ALWAYS) begin
                mem_req_ready_i = 1'b1;
                mem_data_ready_i = 1'b1;
            end else if (ready_mode == MODE_RANDOM) begin
                mem_req_ready_i = 1'($urandom % 2);
                mem_data_ready_i = 1'($urandom % 2);
            end else begin
                mem_req_ready_i = 1'b0;
                mem_data_ready_i = 1'b0;
            end
        end
    end

    // Transfers seen mid-cycle, k-th request paired with k-th data beat
    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (mem_req_valid_o && mem_req_ready_i) begin
                req_q.push_back({mem_req_id_o, mem_req_addr_o});
            end
            if (mem_data_valid_o && mem_data_ready_i) begin
                data_q.push_back({mem_data_o, mem_be_o});
            end
            while (req_q.size() > 0 && data_q.size() > 0) begin
                check_pair(req_q.pop_front(), data_q.pop_front());
            end
        end
    end

    initial begin
        wait (n_vec > 0);
        repeat (n_vec * 40 + 200) @(posedge clk_i);
        $display("timeout: writes still pending after %0d cycles", n_vec * 40 + 200);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [79:0] v;
        logic [3:0] cur_test;
        int err_start;
        clk_i = 1'b0;
        rst_ni = 1'b0;
        st_valid_i = 1'b0;
        st_addr_i = '0;
        st_data_i = '0;
        st_be_i = '0;
        uc_valid_i = 1'b0;
        uc_addr_i = '0;
        uc_data_i = '0;
        uc_be_i = '0;
        mem_req_ready_i = 1'b0;
        mem_data_ready_i = 1'b0;
        $readmemh("dcache_wr_vectors.txt", vectors);
        while (n_vec < MAX_VEC && !$isunknown(vectors[n_vec])) n_vec++;
        repeat (5) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        // Reset state
        @(negedge clk_i);
        check_value("mem_req_valid_o", 0, 32'(mem_req_valid_o));
        check_value("mem_data_valid_o", 0, 32'(mem_data_valid_o));
        check_value("st_ready_o", 1, 32'(st_ready_o));
        check_value("uc_ready_o", 1, 32'(uc_ready_o));
        tests_run++;
        if (errors != 0) tests_failed++;
        $display("test 0: reset state, %0d errors", errors);
        @(posedge clk_i);
        #1;

        cur_test = vectors[0][79:76];
        err_start = errors;
        test_pairs = 0;
        first_set = 1'b0;
        first_checked = 1'b0;
        for (int i = 0; i < n_vec; i++) begin
            v = vectors[i];
            if (v[79:76] != cur_test) begin
                finish_test(cur_test, err_start);
                cur_test = v[79:76];
                err_start = errors;
                test_pairs = 0;
                first_set = 1'b0;
                first_checked = 1'b0;
            end
            ready_mode = v[71:68];
            if (!first_set && v[75:72] inside {KIND_ST, KIND_UC, KIND_BOTH}) begin
                first_exp = (v[75:72] == KIND_ST) ? `WC_ID_WBUF : `WC_ID_UC;
                first_set = 1'b1;
            end
            case (v[75:72])
                KIND_ST: issue(1'b1, 1'b0, v[67:0], '0);
                KIND_UC: issue(1'b0, 1'b1, '0, v[67:0]);
                // Uncached copy carries inverted data so the two sources differ
                KIND_BOTH: issue(1'b1, 1'b1, v[67:0], {v[67:36], ~v[35:4], v[3:0]});
                KIND_FULL: begin
                    @(negedge clk_i);
                    check_value("st_ready_o", 0, 32'(st_ready_o));
                    @(posedge clk_i);
                    #1;
                end
                KIND_GAP: begin
                    @(posedge clk_i);
                    #1;
                end
                default: begin
                    errors++;
                    $display("FAIL %0t: vector %0d has an unknown kind %h", $time, i, v[75:72]);
                end
            endcase
        end
        finish_test(cur_test, err_start);

        if (uut.u_arb.u_chk.fail_count != 0) begin
            errors += uut.u_arb.u_chk.fail_count;
            $display("FAIL %0t: channel assertions failed %0d times",
                     $time, uut.u_arb.u_chk.fail_count);
        end

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dcache_wr_vectors.txt ====
// test_kind_mode_addr_data_be in hex; kind 0 gap, 1 store, 2 uncached, 3 both, 4 expect full
// mode 0 memory always ready, 1 random ready, 2 memory stalled until the test drains
1_1_0_00001000_11111111_f
1_0_0_00000000_00000000_0
1_2_0_40000000_22222222_3
2_1_1_00002000_a0a0a001_f
2_2_1_40000010_b0b0b001_c
2_1_1_00002004_a0a0a002_1
2_1_1_00002008_a0a0a003_8
2_2_1_40000014_b0b0b002_f
2_1_1_0000200c_a0a0a004_6
2_0_1_00000000_00000000_0
2_1_1_00002010_a0a0a005_f
2_2_1_40000018_b0b0b003_5
2_1_1_00002014_a0a0a006_e
3_3_2_00003000_c3c3c3c3_f
4_1_2_00004000_d4d4d401_f
4_2_2_40004000_e4e4e401_a
5_1_2_00005000_f5f5f501_f
5_1_2_00005004_f5f5f502_3
5_1_2_00005008_f5f5f503_c
5_1_2_0000500c_f5f5f504_f
5_4_2_00000000_00000000_0

// ==== build.f ====
+incdir+.
wcache_mem_pkg.sv
wcache_ctrl_pkg.sv
mem_wr_if.sv
wcache_fxarb.sv
mem_write_arbiter.sv
wbuf_drain.sv
uc_write.sv
dcache_wr_top.sv
dcache_wr_chk.sv
dcache_wr_tb.sv
